/* verilog.f */
cpu_isa_pkg.sv
issue_pkg.sv
pipe_classifier.sv
steer.sv
instruction_id_counter.sv
issue_latch.sv
dual_issue_stage.sv
dual_issue_stage_sva.sv
tb_dual_issue_stage.sv

/* Makefile */
TOP = tb_dual_issue_stage

.PHONY: help test clean

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP) +verilator+error+limit+100)"; echo "$$out"; \
	echo "$$out" | grep -q "PASS: all tests"

clean:
	rm -rf obj_dir

/* tb_dual_issue_stage.sv */
`timescale 1ns/1ps

module tb_dual_issue_stage
  import cpu_isa_pkg::*;
();

  logic     clk, reset, stall, fetch_hold, slot1_older;
  inst_t    fetch_instruction0, fetch_instruction1, lane0_instruction, lane1_instruction;
  addr_t    fetch_pc0, fetch_pc1, lane0_pc, lane1_pc;
  inst_id_t lane0_id, lane1_id;
  int       cycles = 0;

  dual_issue_stage uut (.*);

  bind dual_issue_stage dual_issue_stage_sva u_sva (.*);

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // watchdog.
  //////////////////////////////////////////////////

  // 209 pairs, two accepted cycles at most, one cycle in four stalled.
  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (uut.u_sva.fail_count != 0) begin
      $display("FAIL: see errors above");
      $fatal(1, "assertion failed");
    end else if (cycles >= 2000) begin
      $display("timeout, test still running after %0d cycles", cycles);
      $display("FAIL: see errors above");
      $fatal(1, "timeout");
    end
  end

  // cls 0 don't-care, 1 branch, 2 memory.
  function automatic inst_t class_inst(int cls, bit pick);
    opcode_t op;
    case (cls)
      0: op = pick ? 6'b000001 : 6'b010010;
      1: op = pick ? OP_CODE_CMPI : 6'b110001;
      default: op = pick ? 6'b100001 : 6'b100000;
    endcase
    return {op, 26'($urandom)};
  endfunction

  task automatic present_pair(input inst_t inst0, input inst_t inst1, input bit random_stall);
    addr_t pc;
    bit    taken;
    pc = addr_t'($urandom & 32'hfffc);
    fetch_instruction0 <= inst0;
    fetch_instruction1 <= inst1;
    fetch_pc0          <= pc;
    fetch_pc1          <= pc + addr_t'(4);
    do begin
      @(posedge clk);
      taken = !fetch_hold; // pair gone once hold drops.
      stall <= random_stall && ($urandom % 4 == 0);
    end while (!taken);
  endtask

  initial begin
    void'($urandom(66475));
    reset              <= 1'b1;
    stall              <= 1'b0;
    fetch_instruction0 <= NOP_INSTRUCTION;
    fetch_instruction1 <= NOP_INSTRUCTION;
    fetch_pc0          <= '0;
    fetch_pc1          <= '0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;

    for (int c0 = 0; c0 < 3; c0++) begin
      for (int c1 = 0; c1 < 3; c1++) begin
        present_pair(class_inst(c0, c1[0]), class_inst(c1, c0[0]), 1'b0);
      end
    end
    for (int n = 0; n < 200; n++) begin
      present_pair(inst_t'($urandom), inst_t'($urandom), 1'b1);
    end
    stall <= 1'b0;
    repeat (3) @(posedge clk);

    if (uut.u_sva.fail_count == 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      $display("FAIL: see errors above");
      $fatal(1, "assertion failed");
    end
  end

endmodule

/* dual_issue_stage_sva.sv */
`timescale 1ns/1ps

module dual_issue_stage_sva
  import cpu_isa_pkg::*;
  import issue_pkg::*;
(
  input logic     clk, reset, stall, fetch_hold, slot1_older,
  input inst_t    fetch_instruction0, fetch_instruction1,
  input addr_t    fetch_pc0, fetch_pc1,
  input inst_t    lane0_instruction, lane1_instruction,
  input addr_t    lane0_pc, lane1_pc,
  input inst_id_t lane0_id, lane1_id
);

  typedef logic [INST_WIDTH+ADDR_WIDTH+INST_ID_WIDTH-1:0] lane_t; // {instruction, pc, id}.

  int unsigned fail_count = 0;
  inst_id_t    next_id;
  logic        split_flag; // second half of a split pair.
  logic        exp_older;
  lane_t       exp_lane0, exp_lane1, slot0, slot1;
  pipe_class_t class0, class1;
  logic        both_branch, both_memory, swapped, split_now;

  function automatic pipe_class_t class_of(inst_t inst);
    opcode_t op;
    op = inst[OPCODE_MSB:OPCODE_LSB];
    class_of = PIPE_DONT_CARE;
    if (op[5:4] == 2'b10)
      class_of = PIPE_MEMORY;
    else if (op[5:4] == 2'b11 || op == OP_CODE_CMP || op == OP_CODE_TEST ||
             op == OP_CODE_CMPI || op == OP_CODE_TESTI)
      class_of = PIPE_BRANCH; // jumps, compares, tests.
  endfunction

  //////////////////////////////////////////////////
  // expected lanes.
  //////////////////////////////////////////////////

  assign class0      = class_of(fetch_instruction0);
  assign class1      = class_of(fetch_instruction1);
  assign both_branch = class0 == PIPE_BRANCH && class1 == PIPE_BRANCH;
  assign both_memory = class0 == PIPE_MEMORY && class1 == PIPE_MEMORY;
  assign swapped     = (class0 == PIPE_MEMORY && class1 != PIPE_MEMORY) ||
                       (class0 == PIPE_DONT_CARE && class1 == PIPE_BRANCH);
  assign split_now   = (both_branch || both_memory) && !split_flag;
  assign slot0       = {fetch_instruction0, fetch_pc0, next_id};
  assign slot1       = {fetch_instruction1, fetch_pc1, next_id + inst_id_t'(1)};

  always_ff @(posedge clk) begin
    if (reset) begin
      next_id    <= '0;
      split_flag <= 1'b0;
      exp_lane0  <= '0; // nop, pc 0, id 0.
      exp_lane1  <= '0;
      exp_older  <= 1'b0;
    end else if (!stall) begin
      split_flag <= split_now;
      if (!split_now)
        next_id <= next_id + inst_id_t'(2);
      exp_lane0 <= both_memory ? '0 : (swapped || (both_branch && split_flag)) ? slot1 : slot0;
      exp_lane1 <= both_branch ? '0 : (swapped || (both_memory && !split_flag)) ? slot0 : slot1;
      exp_older <= swapped || both_memory;
    end
  end

  //////////////////////////////////////////////////
  // port checks.
  //////////////////////////////////////////////////

  lane0_steered: assert property (@(posedge clk) disable iff (reset)
    {lane0_instruction, lane0_pc, lane0_id} == exp_lane0)
    else begin
      $error("FAIL %0t lane0 {instruction, pc, id} got %h expected %h", $time,
             $sampled({lane0_instruction, lane0_pc, lane0_id}), $sampled(exp_lane0));
      fail_count++;
    end

  lane1_steered: assert property (@(posedge clk) disable iff (reset)
    {lane1_instruction, lane1_pc, lane1_id} == exp_lane1)
    else begin
      $error("FAIL %0t lane1 {instruction, pc, id} got %h expected %h", $time,
             $sampled({lane1_instruction, lane1_pc, lane1_id}), $sampled(exp_lane1));
      fail_count++;
    end

  older_flag: assert property (@(posedge clk) disable iff (reset) slot1_older == exp_older)
    else begin
      $error("FAIL %0t slot1_older got %b expected %b", $time, $sampled(slot1_older),
             $sampled(exp_older));
      fail_count++;
    end

  hold_level: assert property (@(posedge clk) disable iff (reset)
    fetch_hold == (stall || split_now))
    else begin
      $error("FAIL %0t fetch_hold got %b expected %b", $time, $sampled(fetch_hold),
             $sampled(stall || split_now));
      fail_count++;
    end

  // whole stage frozen for a stalled cycle.
  stall_freezes: assert property (@(posedge clk) disable iff (reset)
    stall |=> $stable({lane0_instruction, lane0_pc, lane0_id, lane1_instruction, lane1_pc,
                       lane1_id, slot1_older}))
    else begin
      $error("lane outputs changed during a stall");
      fail_count++;
    end

endmodule

/* dual_issue_stage.sv */
`timescale 1ns/1ps

module dual_issue_stage
  import cpu_isa_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,

  input  inst_t    fetch_instruction0,
  input  inst_t    fetch_instruction1,
  input  addr_t    fetch_pc0,
  input  addr_t    fetch_pc1,

  output logic     fetch_hold,
  output inst_t    lane0_instruction,
  output addr_t    lane0_pc,
  output inst_id_t lane0_id,
  output inst_t    lane1_instruction,
  output addr_t    lane1_pc,
  output inst_id_t lane1_id,
  output logic     slot1_older
);

  inst_id_t id0;
  inst_id_t id1;
  inst_t    steer_instruction0;
  inst_t    steer_instruction1;
  addr_t    steer_pc0;
  addr_t    steer_pc1;
  inst_id_t steer_id0;
  inst_id_t steer_id1;
  logic     steer_stall;
  logic     first;
  logic     advance;

  assign fetch_hold = stall | steer_stall;
  assign advance    = !stall && !steer_stall; // pair fully issued.

  instruction_id_counter u_id_counter (
    .clk     (clk),
    .reset   (reset),
    .advance (advance),
    .id0     (id0),
    .id1     (id1)
  );

  steer u_steer (
    .clk              (clk),
    .reset            (reset),
    .stall            (stall),
    .instruction0_in  (fetch_instruction0),
    .instruction1_in  (fetch_instruction1),
    .pc0_in           (fetch_pc0),
    .pc1_in           (fetch_pc1),
    .id0_in           (id0),
    .id1_in           (id1),
    .instruction0_out (steer_instruction0),
    .instruction1_out (steer_instruction1),
    .pc0_out          (steer_pc0),
    .pc1_out          (steer_pc1),
    .id0_out          (steer_id0),
    .id1_out          (steer_id1),
    .steer_stall      (steer_stall),
    .first            (first)
  );

  issue_latch u_issue_latch (
    .clk               (clk),
    .reset             (reset),
    .stall             (stall),
    .instruction0_in   (steer_instruction0),
    .instruction1_in   (steer_instruction1),
    .pc0_in            (steer_pc0),
    .pc1_in            (steer_pc1),
    .id0_in            (steer_id0),
    .id1_in            (steer_id1),
    .first             (first),
    .lane0_instruction (lane0_instruction),
    .lane0_pc          (lane0_pc),
    .lane0_id          (lane0_id),
    .lane1_instruction (lane1_instruction),
    .lane1_pc          (lane1_pc),
    .lane1_id          (lane1_id),
    .slot1_older       (slot1_older)
  );

endmodule

/* issue_latch.sv */
`timescale 1ns/1ps

module issue_latch
  import cpu_isa_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,

  input  inst_t    instruction0_in,
  input  inst_t    instruction1_in,
  input  addr_t    pc0_in,
  input  addr_t    pc1_in,
  input  inst_id_t id0_in,
  input  inst_id_t id1_in,
  input  logic     first,

  output inst_t    lane0_instruction,
  output addr_t    lane0_pc,
  output inst_id_t lane0_id,
  output inst_t    lane1_instruction,
  output addr_t    lane1_pc,
  output inst_id_t lane1_id,
  output logic     slot1_older
);

  always_ff @(posedge clk) begin
    if (reset) begin
      lane0_instruction <= NOP_INSTRUCTION;
      lane0_pc          <= '0;
      lane0_id          <= '0;
      lane1_instruction <= NOP_INSTRUCTION;
      lane1_pc          <= '0;
      lane1_id          <= '0;
      slot1_older       <= 1'b0;
    end else if (!stall) begin
      lane0_instruction <= instruction0_in;
      lane0_pc          <= pc0_in;
      lane0_id          <= id0_in;
      lane1_instruction <= instruction1_in;
      lane1_pc          <= pc1_in;
      lane1_id          <= id1_in;
      slot1_older       <= first; // lane 1 holds the older op.
    end
  end

endmodule

/* instruction_id_counter.sv */
`timescale 1ns/1ps

module instruction_id_counter
  import cpu_isa_pkg::*;
  import issue_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     advance,
  output inst_id_t id0,
  output inst_id_t id1
);

  inst_id_t next_id;

  always_ff @(posedge clk) begin
    if (reset) begin
      next_id <= '0;
    end else if (advance) begin
      next_id <= next_id + inst_id_t'(NUM_LANES); // one id per lane.
    end
  end

  assign id0 = next_id;
  assign id1 = next_id + inst_id_t'(1); // wraps at 256.

endmodule

/* steer.sv */
`timescale 1ns/1ps

module steer
  import cpu_isa_pkg::*;
  import issue_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  logic     stall,

  input  inst_t    instruction0_in,
  input  inst_t    instruction1_in,
  input  addr_t    pc0_in,
  input  addr_t    pc1_in,
  input  inst_id_t id0_in,
  input  inst_id_t id1_in,

  output inst_t    instruction0_out,
  output inst_t    instruction1_out,
  output addr_t    pc0_out,
  output addr_t    pc1_out,
  output inst_id_t id0_out,
  output inst_id_t id1_out,
  output logic     steer_stall,
  output logic     first
);

  pipe_class_t class0;
  pipe_class_t class1;
  logic        second_half; // inside the second cycle of a split.

  //////////////////////////////////////////////////
  // classify both slots.
  //////////////////////////////////////////////////

  pipe_classifier u_class0 (
    .opcode     (instruction0_in[OPCODE_MSB:OPCODE_LSB]),
    .pipe_class (class0)
  );

  pipe_classifier u_class1 (
    .opcode     (instruction1_in[OPCODE_MSB:OPCODE_LSB]),
    .pipe_class (class1)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      second_half <= 1'b0;
    end else if (!stall) begin
      second_half <= steer_stall;
    end
  end

  //////////////////////////////////////////////////
  // lane placement.
  //////////////////////////////////////////////////

  always_comb begin
    // straight through unless a rule below applies.
    instruction0_out = instruction0_in;
    instruction1_out = instruction1_in;
    pc0_out          = pc0_in;
    pc1_out          = pc1_in;
    id0_out          = id0_in;
    id1_out          = id1_in;
    steer_stall      = 1'b0;
    first            = 1'b0;

    case ({class0, class1})
      {PIPE_BRANCH, PIPE_BRANCH}: begin
        // both want lane 0, older goes first.
        instruction0_out = second_half ? instruction1_in : instruction0_in;
        pc0_out          = second_half ? pc1_in : pc0_in;
        id0_out          = second_half ? id1_in : id0_in;
        instruction1_out = NOP_INSTRUCTION;
        pc1_out          = '0;
        id1_out          = '0;
        steer_stall      = !second_half;
      end
      {PIPE_MEMORY, PIPE_MEMORY}: begin
        instruction0_out = NOP_INSTRUCTION;
        pc0_out          = '0;
        id0_out          = '0;
        instruction1_out = second_half ? instruction1_in : instruction0_in;
        pc1_out          = second_half ? pc1_in : pc0_in;
        id1_out          = second_half ? id1_in : id0_in;
        steer_stall      = !second_half;
        first            = 1'b1;
      end
      {PIPE_MEMORY, PIPE_BRANCH},
      {PIPE_MEMORY, PIPE_DONT_CARE},
      {PIPE_DONT_CARE, PIPE_BRANCH}: begin
        instruction0_out = instruction1_in; // swap lanes.
        instruction1_out = instruction0_in;
        pc0_out          = pc1_in;
        pc1_out          = pc0_in;
        id0_out          = id1_in;
        id1_out          = id0_in;
        first            = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

/* pipe_classifier.sv */
`timescale 1ns/1ps

module pipe_classifier
  import cpu_isa_pkg::*;
  import issue_pkg::*;
(
  input  opcode_t     opcode,
  output pipe_class_t pipe_class
);

  always_comb begin
    pipe_class = PIPE_DONT_CARE;
    if (opcode == '0) begin
      pipe_class = PIPE_DONT_CARE; // nop.
    end else begin
      case (opcode[OPCODE_WIDTH-1 -: 2])
        2'b00: begin // add, sub...
          if (opcode == OP_CODE_CMP || opcode == OP_CODE_TEST) begin
            pipe_class = PIPE_BRANCH;
          end
        end
        2'b01: begin // addi, subi...
          if (opcode == OP_CODE_CMPI || opcode == OP_CODE_TESTI) begin
            pipe_class = PIPE_BRANCH;
          end
        end
        2'b10: begin
          pipe_class = PIPE_MEMORY; // loads and stores.
        end
        default: begin
          pipe_class = PIPE_BRANCH; // jumps.
        end
      endcase
    end
  end

endmodule

/* issue_pkg.sv */
package issue_pkg;

  //////////////////////////////////////////////////
  // lane steering classes.
  //////////////////////////////////////////////////

  // lane 0 takes branches, lane 1 takes memory ops.
  typedef enum logic [1:0] {
    PIPE_DONT_CARE = 2'd0,
    PIPE_BRANCH    = 2'd1,
    PIPE_MEMORY    = 2'd2
  } pipe_class_t;

  // also the id step per issued pair.
  localparam int NUM_LANES = 2;

endpackage

/* cpu_isa_pkg.sv */
package cpu_isa_pkg;

  //////////////////////////////////////////////////
  // word widths.
  //////////////////////////////////////////////////

  localparam int INST_WIDTH    = 32;
  localparam int ADDR_WIDTH    = 16;
  localparam int INST_ID_WIDTH = 8;
  localparam int OPCODE_WIDTH  = 6;

  typedef logic [INST_WIDTH-1:0]    inst_t;
  typedef logic [ADDR_WIDTH-1:0]    addr_t;
  typedef logic [INST_ID_WIDTH-1:0] inst_id_t; // wraps around.
  typedef logic [OPCODE_WIDTH-1:0]  opcode_t;

  // opcode sits in the top bits of the word.
  localparam int OPCODE_MSB = INST_WIDTH - 1;
  localparam int OPCODE_LSB = INST_WIDTH - OPCODE_WIDTH;

  //////////////////////////////////////////////////
  // opcodes.
  //////////////////////////////////////////////////

  // group 00, register alu.
  localparam opcode_t OP_CODE_CMP   = 6'b001100;
  localparam opcode_t OP_CODE_TEST  = 6'b001101;

  // group 01, immediate alu.
  localparam opcode_t OP_CODE_CMPI  = 6'b011100;
  localparam opcode_t OP_CODE_TESTI = 6'b011101;

  localparam inst_t NOP_INSTRUCTION = '0;

endpackage
